// File: Makefile
# Verilator flow for the decode stage testbench

VERILATOR   ?= verilator
TOP         ?= decode_stage_tb
FILELIST    ?= files.f
OBJ_DIR     ?= obj_dir
ERROR_LIMIT ?= 100
VFLAGS      ?= --timing --assert --timescale 1ns/1ps
PASS_MSG    := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# pass only when the pass message shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
src/decode_pkg.sv
src/instr_decoder.sv
src/operand_select.sv
src/fence_tracker.sv
src/decode_execute_latch.sv
src/decode_stage.sv
verification/decode_stage_asserts.sv
verification/decode_stage_tb.sv

// File: src/decode_execute_latch.sv
////////////////////////////////////////
// decode to execute latch
// accepts, tags and allocates one instr
// per strobe, cleared by flush
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode_execute_latch import decode_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     instr_valid,
  input  logic     flush,
  input  logic     is_fence,
  input  tag_t     cur_tail,
  input  reg_idx_t rd,
  input  alu_op_e  alu_op,
  input  fu_type_e fu_type,
  input  logic     wen,
  input  logic     illegal,
  input  word_t    port_a,
  input  word_t    port_b,
  input  word_t    store_data,
  output logic     alloc_ena,
  output logic     ex_valid,
  output logic     ex_wen,
  output logic     ex_illegal,
  output tag_t     ex_tag,
  output reg_idx_t ex_rd,
  output alu_op_e  ex_alu_op,
  output fu_type_e ex_fu_type,
  output word_t    ex_port_a,
  output word_t    ex_port_b,
  output word_t    ex_store_data
);

  logic accept;

  // fences never enter the completion buffer
  // illegal words still allocate so the fault retires in order
  assign accept    = instr_valid && !is_fence && !flush;
  assign alloc_ena = accept;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_valid   <= 1'b0;
      ex_wen     <= 1'b0;
      ex_illegal <= 1'b0;
    end else begin
      ex_valid   <= accept;
      ex_wen     <= accept && wen;
      ex_illegal <= accept && illegal;
    end
  end

  // payload zeroed in bubble cycles
  always_ff @(posedge CLK) begin
    if (accept) begin
      ex_tag        <= cur_tail;
      ex_rd         <= rd;
      ex_alu_op     <= alu_op;
      ex_fu_type    <= fu_type;
      ex_port_a     <= port_a;
      ex_port_b     <= port_b;
      ex_store_data <= store_data;
    end else begin
      ex_tag        <= '0;
      ex_rd         <= '0;
      ex_alu_op     <= ADD;
      ex_fu_type    <= FU_ARITH;
      ex_port_a     <= '0;
      ex_port_b     <= '0;
      ex_store_data <= '0;
    end
  end

endmodule

`default_nettype wire

// File: src/decode_pkg.sv
////////////////////////////////////////
// decode package
// widths, opcodes, the instruction word
// union and the decode control encodings
////////////////////////////////////////
`default_nettype none

package decode_pkg;

  localparam int XLEN      = 32;
  localparam int REG_W     = 5;
  localparam int ROB_DEPTH = 8;
  localparam int TAG_W     = $clog2(ROB_DEPTH);

  typedef logic [XLEN-1:0]  word_t;
  typedef logic [REG_W-1:0] reg_idx_t;
  typedef logic [TAG_W-1:0] tag_t;

  // rv32i major opcodes kept by this stage
  typedef enum logic [6:0] {
    OP       = 7'b0110011,
    OP_IMM   = 7'b0010011,
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    LOAD     = 7'b0000011,
    STORE    = 7'b0100011,
    MISC_MEM = 7'b0001111
  } opcode_e;

  // r type, also the source of reg and funct fields for all formats
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_e     opcode;
  } i_fmt_t;

  // store immediate split around rs2/rs1
  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    opcode_e     opcode;
  } u_fmt_t;

  // one fetched word, several readings
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
  } instr_u;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } alu_op_e;

  typedef enum logic {FU_ARITH, FU_LSU} fu_type_e;

  typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_e;

  typedef enum logic {SRC_B_RS2, SRC_B_IMM} src_b_e;

  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U} imm_fmt_e;

endpackage

`default_nettype wire

// File: src/decode_stage.sv
////////////////////////////////////////
// ooo decode stage
// decoder, operand select, fence logic
// and the decode to execute latch
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode_stage import decode_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     instr_valid,
  input  word_t    instr,
  input  word_t    pc,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  logic     flush,
  input  tag_t     cur_tail,
  input  logic     iflush_done,
  input  logic     dflush_done,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output logic     alloc_ena,
  output logic     icache_flush,
  output logic     dcache_flush,
  output logic     fence_pending,
  output logic     ex_valid,
  output tag_t     ex_tag,
  output reg_idx_t ex_rd,
  output alu_op_e  ex_alu_op,
  output fu_type_e ex_fu_type,
  output logic     ex_wen,
  output logic     ex_illegal,
  output word_t    ex_port_a,
  output word_t    ex_port_b,
  output word_t    ex_store_data
);

  // decoder outputs
  reg_idx_t rd;
  alu_op_e  alu_op;
  fu_type_e fu_type;
  src_a_e   src_a;
  src_b_e   src_b;
  imm_fmt_e imm_fmt;
  logic     wen;
  logic     is_fence;
  logic     illegal;
  // operand values
  word_t    port_a;
  word_t    port_b;
  word_t    store_data;

  instr_decoder dec0 (
    .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd),
    .alu_op(alu_op), .fu_type(fu_type), .src_a(src_a), .src_b(src_b),
    .imm_fmt(imm_fmt), .wen(wen), .is_fence(is_fence), .illegal(illegal)
  );

  // rs1/rs2 data come back from the register file in the same cycle
  operand_select opsel0 (
    .instr(instr), .imm_fmt(imm_fmt), .src_a(src_a), .src_b(src_b),
    .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .port_a(port_a), .port_b(port_b), .store_data(store_data)
  );

  fence_tracker fence0 (
    .CLK(CLK), .nRST(nRST), .instr_valid(instr_valid), .is_fence(is_fence),
    .iflush_done(iflush_done), .dflush_done(dflush_done),
    .icache_flush(icache_flush), .dcache_flush(dcache_flush),
    .fence_pending(fence_pending)
  );

  decode_execute_latch latch0 (
    .CLK(CLK), .nRST(nRST), .instr_valid(instr_valid), .flush(flush),
    .is_fence(is_fence), .cur_tail(cur_tail), .rd(rd), .alu_op(alu_op),
    .fu_type(fu_type), .wen(wen), .illegal(illegal),
    .port_a(port_a), .port_b(port_b), .store_data(store_data),
    .alloc_ena(alloc_ena), .ex_valid(ex_valid), .ex_wen(ex_wen),
    .ex_illegal(ex_illegal), .ex_tag(ex_tag), .ex_rd(ex_rd),
    .ex_alu_op(ex_alu_op), .ex_fu_type(ex_fu_type), .ex_port_a(ex_port_a),
    .ex_port_b(ex_port_b), .ex_store_data(ex_store_data)
  );

endmodule

`default_nettype wire

// File: src/fence_tracker.sv
////////////////////////////////////////
// fence tracker
// one cache flush pulse per fence run,
// pending until both caches are done
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fence_tracker (
  input  logic CLK,
  input  logic nRST,
  input  logic instr_valid,
  input  logic is_fence,
  input  logic iflush_done,
  input  logic dflush_done,
  output logic icache_flush,
  output logic dcache_flush,
  output logic fence_pending
);

  logic last_fence;
  logic fence_pulse;
  logic iflushed;
  logic dflushed;

  // was the previous strobed instr a fence
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      last_fence <= 1'b0;
    end else if (instr_valid) begin
      last_fence <= is_fence;
    end
  end

  // rising edge of a fence run
  assign fence_pulse  = instr_valid && is_fence && !last_fence;
  assign icache_flush = fence_pulse;
  assign dcache_flush = fence_pulse;

  // new pulse wins over a late done
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      iflushed <= 1'b1;
      dflushed <= 1'b1;
    end else begin
      if (fence_pulse) begin
        iflushed <= 1'b0;
      end else if (iflush_done) begin
        iflushed <= 1'b1;
      end
      if (fence_pulse) begin
        dflushed <= 1'b0;
      end else if (dflush_done) begin
        dflushed <= 1'b1;
      end
    end
  end

  assign fence_pending = !iflushed || !dflushed;

endmodule

`default_nettype wire

// File: src/instr_decoder.sv
////////////////////////////////////////
// instruction decoder
// opcode/funct to alu op, unit, source
// selects, write enable and illegal flag
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import decode_pkg::*; (
  input  instr_u   instr,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output alu_op_e  alu_op,
  output fu_type_e fu_type,
  output src_a_e   src_a,
  output src_b_e   src_b,
  output imm_fmt_e imm_fmt,
  output logic     wen,
  output logic     is_fence,
  output logic     illegal
);

  // funct3 to alu op, alt is funct7 bit 5
  // sub only for register forms, addi keeps its imm bit
  function automatic alu_op_e alu_from_funct(input logic [2:0] funct3,
                                              input logic alt,
                                              input logic allow_sub);
    alu_op_e op;
    case (funct3)
      3'b000:  op = (alt && allow_sub) ? SUB : ADD;
      3'b001:  op = SLL;
      3'b010:  op = SLT;
      3'b011:  op = SLTU;
      3'b100:  op = XOR;
      3'b101:  op = alt ? SRA : SRL;
      3'b110:  op = OR;
      default: op = AND;
    endcase
    return op;
  endfunction

  // register indices straight from the word
  assign rs1 = instr.r_fmt.rs1;
  assign rs2 = instr.r_fmt.rs2;
  assign rd  = instr.r_fmt.rd;

  always_comb begin
    // defaults match an i type arith op
    alu_op   = ADD;
    fu_type  = FU_ARITH;
    src_a    = SRC_A_RS1;
    src_b    = SRC_B_IMM;
    imm_fmt  = IMM_I;
    wen      = 1'b1;
    is_fence = 1'b0;
    illegal  = 1'b0;
    case (instr.r_fmt.opcode)
      OP: begin
        src_b  = SRC_B_RS2;
        alu_op = alu_from_funct(instr.r_fmt.funct3, instr.r_fmt.funct7[5], 1'b1);
        // only 0x00 and 0x20 exist in base rv32i
        illegal = (instr.r_fmt.funct7 != 7'h00) && (instr.r_fmt.funct7 != 7'h20);
      end
      OP_IMM: begin
        alu_op = alu_from_funct(instr.r_fmt.funct3, instr.r_fmt.funct7[5], 1'b0);
      end
      // zero + upper imm
      LUI: begin
        src_a   = SRC_A_ZERO;
        imm_fmt = IMM_U;
      end
      AUIPC: begin
        src_a   = SRC_A_PC;
        imm_fmt = IMM_U;
      end
      // address = rs1 + imm
      LOAD: fu_type = FU_LSU;
      STORE: begin
        fu_type = FU_LSU;
        imm_fmt = IMM_S;
        wen     = 1'b0;
      end
      MISC_MEM: begin
        is_fence = 1'b1;
        wen      = 1'b0;
      end
      default: illegal = 1'b1;
    endcase
    // nothing written back for a bad word
    if (illegal) begin
      wen = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/operand_select.sv
////////////////////////////////////////
// operand select
// immediate extension and the two
// functional unit port muxes
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module operand_select import decode_pkg::*; (
  input  instr_u   instr,
  input  imm_fmt_e imm_fmt,
  input  src_a_e   src_a,
  input  src_b_e   src_b,
  input  word_t    pc,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  output word_t    port_a,
  output word_t    port_b,
  output word_t    store_data
);

  word_t imm_i_ext;
  word_t imm_s_ext;
  word_t imm_u_ext;
  word_t imm;

  // sign extend from bit 11
  assign imm_i_ext = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
  assign imm_s_ext = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
  // upper imm, low 12 bits zero
  assign imm_u_ext = {instr.u_fmt.imm, 12'h000};

  always_comb begin
    case (imm_fmt)
      IMM_I:   imm = imm_i_ext;
      IMM_S:   imm = imm_s_ext;
      IMM_U:   imm = imm_u_ext;
      default: imm = '0;
    endcase
  end

  // port a: rs1, pc for auipc, zero for lui
  always_comb begin
    case (src_a)
      SRC_A_RS1: port_a = rs1_data;
      SRC_A_PC:  port_a = pc;
      default:   port_a = '0;
    endcase
  end

  assign port_b = (src_b == SRC_B_RS2) ? rs2_data : imm;

  // lsu picks this up only for stores
  assign store_data = rs2_data;

endmodule

`default_nettype wire

// File: verification/decode_stage_asserts.sv
////////////////////////////////////////
// decode stage assertions
// flush, cache flush and allocation
// rules, bound into the top level
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode_stage_asserts (
  input logic CLK,
  input logic nRST,
  input logic instr_valid,
  input logic flush,
  input logic alloc_ena,
  input logic ex_valid,
  input logic icache_flush,
  input logic dcache_flush
);

  // failures so far
  int fail_count = 0;

  // flushed instr never reaches execute
  flush_blocks_ex: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !ex_valid)
    else begin
      fail_count++;
      $error("ex_valid high in the cycle after a flush");
    end

  // both caches always flushed together
  flush_pulses_match: assert property (@(posedge CLK) disable iff (!nRST)
    icache_flush == dcache_flush)
    else begin
      fail_count++;
      $error("icache_flush and dcache_flush differ");
    end

  // no allocation without a strobe
  alloc_needs_valid: assert property (@(posedge CLK) disable iff (!nRST)
    !instr_valid |-> !alloc_ena)
    else begin
      fail_count++;
      $error("alloc_ena high while instr_valid is low");
    end

endmodule

bind decode_stage decode_stage_asserts asserts0 (
  .CLK(CLK), .nRST(nRST), .instr_valid(instr_valid), .flush(flush),
  .alloc_ena(alloc_ena), .ex_valid(ex_valid), .icache_flush(icache_flush),
  .dcache_flush(dcache_flush)
);

`default_nettype wire

// File: verification/decode_stage_tb.sv
////////////////////////////////////////
// decode stage testbench
// replays the stimulus file one line per
// cycle and checks every output
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb import decode_pkg::*; ();

  localparam int    CLK_PERIOD    = 10;
  localparam int    DRIVE_DELAY   = 1;
  localparam int    RST_CYCLES    = 5;
  localparam int    MARGIN_CYCLES = 20;
  localparam int    N_FIELDS      = 20;
  localparam string STIM_FILE     = "verification/decode_stimulus.txt";
  localparam byte   COMMENT_CHAR  = "#";

  logic     CLK;
  logic     nRST;
  logic     instr_valid;
  word_t    instr;
  word_t    pc;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     flush;
  tag_t     cur_tail;
  logic     iflush_done;
  logic     dflush_done;
  reg_idx_t rs1;
  reg_idx_t rs2;
  logic     alloc_ena;
  logic     icache_flush;
  logic     dcache_flush;
  logic     fence_pending;
  logic     ex_valid;
  tag_t     ex_tag;
  reg_idx_t ex_rd;
  alu_op_e  ex_alu_op;
  fu_type_e ex_fu_type;
  logic     ex_wen;
  logic     ex_illegal;
  word_t    ex_port_a;
  word_t    ex_port_b;
  word_t    ex_store_data;

  // test lines, current line number, and its fields
  string       lines[$];
  int          cur_line;
  logic        stim_loaded = 1'b0;
  logic [31:0] s_valid, s_instr, s_pc, s_flush, s_tail, s_idone, s_ddone;
  logic [31:0] e_alloc, e_cflush, e_pend, e_valid, e_tag, e_rd, e_op;
  logic [31:0] e_fu, e_wen, e_ill, e_port_a, e_port_b, e_store;

  // register file model, every byte holds the index
  function automatic word_t reg_value(input reg_idx_t idx);
    return {4{3'b000, idx}};
  endfunction

  // combinational read, same cycle as the index
  assign rs1_data = reg_value(rs1);
  assign rs2_data = reg_value(rs2);

  decode_stage dut0 (
    .CLK(CLK), .nRST(nRST), .instr_valid(instr_valid), .instr(instr), .pc(pc),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .flush(flush), .cur_tail(cur_tail),
    .iflush_done(iflush_done), .dflush_done(dflush_done), .rs1(rs1), .rs2(rs2),
    .alloc_ena(alloc_ena), .icache_flush(icache_flush), .dcache_flush(dcache_flush),
    .fence_pending(fence_pending), .ex_valid(ex_valid), .ex_tag(ex_tag),
    .ex_rd(ex_rd), .ex_alu_op(ex_alu_op), .ex_fu_type(ex_fu_type), .ex_wen(ex_wen),
    .ex_illegal(ex_illegal), .ex_port_a(ex_port_a), .ex_port_b(ex_port_b),
    .ex_store_data(ex_store_data)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h got %h on test line %0d",
               name, expected, actual, cur_line);
      $display("Test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic load_stimulus();
    int    fd;
    int    n;
    string line;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %s", STIM_FILE);
      $display("Test failed");
      $fatal(1, "no stimulus");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // blank and comment lines carry no test
      if (n > 1 && line.getc(0) != COMMENT_CHAR) begin
        lines.push_back(line);
      end
    end
    $fclose(fd);
    if (lines.size() == 0) begin
      $display("the stimulus file holds no test lines");
      $display("Test failed");
      $fatal(1, "empty stimulus");
    end
  endtask

  // inputs first, then outputs expected in that cycle
  task automatic parse_fields(input string line);
    int n;
    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                s_valid, s_instr, s_pc, s_flush, s_tail, s_idone, s_ddone,
                e_alloc, e_cflush, e_pend, e_valid, e_tag, e_rd, e_op, e_fu,
                e_wen, e_ill, e_port_a, e_port_b, e_store);
    if (n != N_FIELDS) begin
      $display("test line %0d holds %0d fields instead of %0d", cur_line, n, N_FIELDS);
      $display("Test failed");
      $fatal(1, "bad stimulus line");
    end
  endtask

  task automatic drive_inputs();
    instr_valid = s_valid[0];
    instr       = s_instr;
    pc          = s_pc;
    flush       = s_flush[0];
    cur_tail    = s_tail[TAG_W-1:0];
    iflush_done = s_idone[0];
    dflush_done = s_ddone[0];
  endtask

  // ex_* columns belong to the previous line's instr
  task automatic verify_outputs();
    // register indices sit at fixed rv32i bit positions
    compare("rs1", 32'(s_instr[19:15]), 32'(rs1));
    compare("rs2", 32'(s_instr[24:20]), 32'(rs2));
    compare("alloc_ena", e_alloc, 32'(alloc_ena));
    compare("icache_flush", e_cflush, 32'(icache_flush));
    compare("dcache_flush", e_cflush, 32'(dcache_flush));
    compare("fence_pending", e_pend, 32'(fence_pending));
    compare("ex_valid", e_valid, 32'(ex_valid));
    compare("ex_tag", e_tag, 32'(ex_tag));
    compare("ex_rd", e_rd, 32'(ex_rd));
    compare("ex_alu_op", e_op, 32'(ex_alu_op));
    compare("ex_fu_type", e_fu, 32'(ex_fu_type));
    compare("ex_wen", e_wen, 32'(ex_wen));
    compare("ex_illegal", e_ill, 32'(ex_illegal));
    compare("ex_port_a", e_port_a, ex_port_a);
    compare("ex_port_b", e_port_b, ex_port_b);
    compare("ex_store_data", e_store, ex_store_data);
    compare("assertion failures", 32'd0, 32'(dut0.asserts0.fail_count));
  endtask

  initial begin : run
    nRST        = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    flush       = 1'b0;
    cur_tail    = '0;
    iflush_done = 1'b0;
    dflush_done = 1'b0;
    cur_line    = 0;
    load_stimulus();
    stim_loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge CLK);
    #(DRIVE_DELAY);
    nRST = 1'b1;
    // drive just after the edge, check at the falling edge
    foreach (lines[i]) begin
      cur_line = i + 1;
      parse_fields(lines[i]);
      @(posedge CLK);
      #(DRIVE_DELAY);
      drive_inputs();
      @(negedge CLK);
      verify_outputs();
    end
    $display("Test completed successfully");
    $finish;
  end

  // limit from reset, line count and a margin
  initial begin : watchdog
    int limit_ns;
    wait (stim_loaded);
    limit_ns = (RST_CYCLES + lines.size() + MARGIN_CYCLES) * CLK_PERIOD;
    #(limit_ns);
    $display("timeout after %0d ns, the test lines did not finish", limit_ns);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: verification/decode_stimulus.txt
# in: valid instr pc flush tail idone ddone, out: alloc cflush pend
#   ex_valid tag rd alu_op fu wen illegal port_a port_b store (ex_* lag one line)
1 002081B3 00001000 0 1 0 0  1 0 0  0 0 00 0 0 0 0 00000000 00000000 00000000
1 40628233 00001004 0 2 0 0  1 0 0  1 1 03 0 0 1 0 01010101 02020202 02020202
1 409453B3 00001008 0 3 0 0  1 0 0  1 2 04 1 0 1 0 05050505 06060606 06060606
1 00C5F533 0000100C 0 4 0 0  1 0 0  1 3 07 7 0 1 0 08080808 09090909 09090909
1 FFB70693 00001010 0 5 0 0  1 0 0  1 4 0A 9 0 1 0 0B0B0B0B 0C0C0C0C 0C0C0C0C
1 123457B7 00001014 0 6 0 0  1 0 0  1 5 0D 0 0 1 0 0E0E0E0E FFFFFFFB 1B1B1B1B
1 00001817 00001018 0 7 0 0  1 0 0  1 6 0F 0 0 1 0 00000000 12345000 03030303
1 FF892883 0000101C 0 0 0 0  1 0 0  1 7 10 0 0 1 0 00001018 00001000 00000000
1 FF49AA23 00001020 0 1 0 0  1 0 0  1 0 11 0 1 1 0 12121212 FFFFFFF8 18181818
1 002081B3 00001024 1 2 0 0  0 0 0  1 1 14 0 1 0 0 13131313 FFFFFFF4 14141414
0 00000000 00001028 0 2 0 0  0 0 0  0 0 00 0 0 0 0 00000000 00000000 00000000
1 0FF0000F 00001028 0 2 0 0  0 1 0  0 0 00 0 0 0 0 00000000 00000000 00000000
1 0FF0000F 0000102C 0 2 0 0  0 0 1  0 0 00 0 0 0 0 00000000 00000000 00000000
0 00000000 00001030 0 2 1 0  0 0 1  0 0 00 0 0 0 0 00000000 00000000 00000000
0 00000000 00001030 0 2 0 1  0 0 1  0 0 00 0 0 0 0 00000000 00000000 00000000
1 022081B3 00001030 0 3 0 0  1 0 0  0 0 00 0 0 0 0 00000000 00000000 00000000
1 1234567F 00001034 0 4 0 0  1 0 0  1 3 03 0 0 0 1 01010101 02020202 02020202
0 00000000 00001038 0 4 0 0  0 0 0  1 4 0C 0 0 0 1 08080808 00000123 03030303
0 00000000 00001038 0 4 0 0  0 0 0  0 0 00 0 0 0 0 00000000 00000000 00000000
